/* byteRam.sv */
`timescale 1ns/1ps

module byteRam import memPkg::*; #(
    parameter int RAM_ADDR_W = 12
) (
    input  logic   clk,
    input  ramBusT i_bus,
    output byteT   o_rdata
);

    localparam int Depth = 2 ** RAM_ADDR_W;

    byteT mem [Depth];
    logic [RAM_ADDR_W-1:0] rdAddr;

    // memory starts out cleared
    initial begin
        for (int i = 0; i < Depth; i++) begin
            mem[i] = '0;
        end
    end

    // upper address bits are dropped, so addresses wrap
    always_ff @(posedge clk) begin
        if (i_bus.we) begin
            mem[i_bus.addr[RAM_ADDR_W-1:0]] <= i_bus.wdata;
        end
        rdAddr <= i_bus.addr[RAM_ADDR_W-1:0];
    end

    // read data follows its address by one cycle
    assign o_rdata = mem[rdAddr];

endmodule

/* instFetch.sv */
`timescale 1ns/1ps

module instFetch import memPkg::*; (
    input  logic clk,
    input  logic rst,

    input  logic i_redirect,
    input  addrT i_redirectPc,

    // request to the memory controller
    output logic o_fetchEn,
    output addrT o_fetchAddr,
    input  logic i_fetchDone,
    input  wordT i_fetchInst,

    // instruction output buffer
    output logic o_instValid,
    output wordT o_inst,
    output addrT o_instPc,
    input  logic i_instReady
);

    addrT pc;
    logic started;
    logic stale;
    logic instValid;
    logic bufFree;
    logic keepWord;

    // buffer is empty or drains at this edge
    assign bufFree     = !instValid || i_instReady;
    assign o_fetchEn   = started && bufFree;
    assign o_fetchAddr = pc;
    assign o_instValid = instValid;

    // a word aimed at an old pc is thrown away
    assign keepWord = i_fetchDone && !stale && !i_redirect;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= '0;
            started   <= 1'b0;
            stale     <= 1'b0;
            instValid <= 1'b0;
        end else if (i_redirect) begin
            pc        <= i_redirectPc;
            started   <= 1'b1;
            instValid <= 1'b0;
            // word of a still open request belongs to the old stream
            stale     <= o_fetchEn && !i_fetchDone;
        end else begin
            if (i_fetchDone) begin
                stale <= 1'b0;
            end
            if (keepWord) begin
                instValid <= 1'b1;
                pc        <= pc + 32'd4;
            end else if (i_instReady) begin
                instValid <= 1'b0;
            end
        end
    end

    // buffered word and its pc
    always_ff @(posedge clk) begin
        if (keepWord) begin
            o_inst   <= i_fetchInst;
            o_instPc <= pc;
        end
    end

endmodule

/* memCtrl.sv */
`timescale 1ns/1ps

module memCtrl import memPkg::*; (
    input  logic    clk,
    input  logic    rst,

    input  logic    i_rdy,
    input  logic    i_ioFull,

    // data port
    input  logic    i_dcEn,
    input  dataReqT i_dcReq,
    output logic    o_dcDone,
    output wordT    o_dcData,

    // fetch port
    input  logic    i_fetchEn,
    input  addrT    i_fetchAddr,
    output logic    o_fetchDone,
    output wordT    o_fetchInst,

    // byte RAM
    output ramBusT  o_ram,
    input  byteT    i_ramRdata
);

    localparam lenT InstLen = 3'd4;

    ctrlStateT state;
    lenT       stage;

    // latched request
    addrT      reqAddr;
    lenT       reqLen;
    wordT      reqWdata;

    // read bytes shift in from the top with the lowest byte first
    wordT      asmData;
    wordT      rdResult;

    logic      active;
    logic      lastStage;
    logic      done;

    // nothing moves while the core stalls or the io buffer is full
    assign active = i_rdy && !i_ioFull;

    // writes finish on the last byte and reads one stage later
    always_comb begin
        if (state == CtrlWriteData) begin
            lastStage = (stage == lenT'(reqLen - 3'd1));
        end else begin
            lastStage = (stage == reqLen);
        end
    end

    assign done = active && (state != CtrlIdle) && lastStage;

    assign o_dcDone    = done && (state == CtrlReadData || state == CtrlWriteData);
    assign o_fetchDone = done && (state == CtrlReadInst);

    // final byte comes straight from the RAM and short loads are zero-extended
    always_comb begin
        case (reqLen)
            3'd1:    rdResult = {24'b0, i_ramRdata};
            3'd2:    rdResult = {16'b0, i_ramRdata, asmData[31:24]};
            default: rdResult = {i_ramRdata, asmData[31:8]};
        endcase
    end

    assign o_dcData    = rdResult;
    assign o_fetchInst = rdResult;

    // RAM command for the current stage
    always_comb begin
        o_ram.we    = 1'b0;
        o_ram.addr  = '0;
        o_ram.wdata = '0;
        case (state)
            CtrlReadInst, CtrlReadData: begin
                // a stalled cycle repeats the last active address so rdata holds
                if (active) begin
                    o_ram.addr = reqAddr + addrT'(stage);
                end else begin
                    o_ram.addr = reqAddr + addrT'(stage) - addrT'(1);
                end
            end
            CtrlWriteData: begin
                o_ram.we    = active;
                o_ram.addr  = reqAddr + addrT'(stage);
                o_ram.wdata = reqWdata[{stage[1:0], 3'b000} +: 8];
            end
            default: begin
                o_ram.we = 1'b0;
            end
        endcase
    end

    // state and stage counter
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CtrlIdle;
            stage <= '0;
        end else if (active) begin
            case (state)
                CtrlIdle: begin
                    stage <= '0;
                    // data side wins over fetch
                    if (i_dcEn) begin
                        state <= i_dcReq.isStore ? CtrlWriteData : CtrlReadData;
                    end else if (i_fetchEn) begin
                        state <= CtrlReadInst;
                    end
                end
                default: begin
                    if (lastStage) begin
                        state <= CtrlIdle;
                        stage <= '0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
            endcase
        end
    end

    // request latch and read assembly
    always_ff @(posedge clk) begin
        if (active) begin
            if (state == CtrlIdle) begin
                if (i_dcEn) begin
                    reqAddr  <= i_dcReq.addr;
                    reqLen   <= i_dcReq.len;
                    reqWdata <= i_dcReq.wdata;
                end else begin
                    reqAddr <= i_fetchAddr;
                    reqLen  <= InstLen;
                end
            end else if (state != CtrlWriteData && stage != '0) begin
                // byte of the previous stage is on rdata now
                asmData <= {i_ramRdata, asmData[31:8]};
            end
        end
    end

endmodule

/* memPkg.sv */
package memPkg;

    // address, data and byte types
    typedef logic [31:0] addrT;
    typedef logic [31:0] wordT;
    typedef logic [7:0]  byteT;

    // transfer length of 1, 2 or 4 bytes
    typedef logic [2:0]  lenT;

    // data port request held until done
    typedef struct packed {
        logic isStore;
        lenT  len;
        addrT addr;
        wordT wdata;
    } dataReqT;

    // one byte command to the RAM per cycle
    typedef struct packed {
        logic we;
        addrT addr;
        byteT wdata;
    } ramBusT;

    // controller FSM
    typedef enum logic [1:0] {
        CtrlIdle,
        CtrlReadInst,
        CtrlReadData,
        CtrlWriteData
    } ctrlStateT;

endpackage

/* memSubsys.sv */
`timescale 1ns/1ps

module memSubsys import memPkg::*; #(
    parameter int RAM_ADDR_W = 12
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    i_rdy,
    input  logic    i_ioFull,

    input  logic    i_dcEn,
    input  dataReqT i_dcReq,
    output logic    o_dcDone,
    output wordT    o_dcData,

    input  logic    i_redirect,
    input  addrT    i_redirectPc,

    output logic    o_instValid,
    output wordT    o_inst,
    output addrT    o_instPc,
    input  logic    i_instReady
);

    logic   fetchEn;
    addrT   fetchAddr;
    logic   fetchDone;
    wordT   fetchInst;
    ramBusT ramBus;
    byteT   ramRdata;

    instFetch uFetch (
        .clk          (clk),
        .rst          (rst),
        .i_redirect   (i_redirect),
        .i_redirectPc (i_redirectPc),
        .o_fetchEn    (fetchEn),
        .o_fetchAddr  (fetchAddr),
        .i_fetchDone  (fetchDone),
        .i_fetchInst  (fetchInst),
        .o_instValid  (o_instValid),
        .o_inst       (o_inst),
        .o_instPc     (o_instPc),
        .i_instReady  (i_instReady)
    );

    memCtrl uCtrl (
        .clk         (clk),
        .rst         (rst),
        .i_rdy       (i_rdy),
        .i_ioFull    (i_ioFull),
        .i_dcEn      (i_dcEn),
        .i_dcReq     (i_dcReq),
        .o_dcDone    (o_dcDone),
        .o_dcData    (o_dcData),
        .i_fetchEn   (fetchEn),
        .i_fetchAddr (fetchAddr),
        .o_fetchDone (fetchDone),
        .o_fetchInst (fetchInst),
        .o_ram       (ramBus),
        .i_ramRdata  (ramRdata)
    );

    byteRam #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) uRam (
        .clk     (clk),
        .i_bus   (ramBus),
        .o_rdata (ramRdata)
    );

endmodule

/* memSubsys_properties.sv */
`timescale 1ns/1ps

module memSubsys_properties import memPkg::*; (
    input logic   clk,
    input logic   rst,
    input logic   i_rdy,
    input logic   i_ioFull,
    input logic   i_dcEn,
    input logic   o_dcDone,
    input logic   fetchDone,
    input ramBusT ramBus,
    input logic   i_redirect,
    input logic   o_instValid,
    input wordT   o_inst,
    input addrT   o_instPc,
    input logic   i_instReady
);

    // stalled cycles never write the RAM
    assert property (@(posedge clk) disable iff (rst)
        (!i_rdy || i_ioFull) |-> !ramBus.we)
        else $error("RAM write during a stalled cycle");

    assert property (@(posedge clk) disable iff (rst)
        o_dcDone |=> !o_dcDone)
        else $error("data done held for two cycles");

    assert property (@(posedge clk) disable iff (rst)
        fetchDone |=> !fetchDone)
        else $error("fetch done held for two cycles");

    assert property (@(posedge clk) disable iff (rst)
        o_dcDone |-> i_dcEn)
        else $error("data done without a data request");

    // buffered instruction holds under back-pressure
    assert property (@(posedge clk) disable iff (rst)
        (o_instValid && !i_instReady && !i_redirect) |=>
            (o_instValid && $stable(o_inst) && $stable(o_instPc)))
        else $error("instruction changed while stalled by back-pressure");

endmodule

bind memSubsys memSubsys_properties uProps (
    .clk         (clk),
    .rst         (rst),
    .i_rdy       (i_rdy),
    .i_ioFull    (i_ioFull),
    .i_dcEn      (i_dcEn),
    .o_dcDone    (o_dcDone),
    .fetchDone   (fetchDone),
    .ramBus      (ramBus),
    .i_redirect  (i_redirect),
    .o_instValid (o_instValid),
    .o_inst      (o_inst),
    .o_instPc    (o_instPc),
    .i_instReady (i_instReady)
);

/* project.f */
memPkg.sv
byteRam.sv
memCtrl.sv
instFetch.sv
memSubsys.sv
memSubsys_properties.sv
tb_memSubsys.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_memSubsys \
    -f project.f \
    -o simv

out=$(./obj_dir/simv) || true
echo "$out"

if grep -q "SIMULATION PASSED" <<< "$out"; then
    exit 0
fi
exit 1

/* tb_memSubsys.sv */
`timescale 1ns/1ps

module tb_memSubsys;
    import memPkg::*;

    localparam int RamAddrW  = 12;
    localparam int Depth     = 2 ** RamAddrW;
    localparam int MaxCycles = 20000;

    logic    clk;
    logic    rst;
    logic    i_rdy;
    logic    i_ioFull;
    logic    i_dcEn;
    dataReqT i_dcReq;
    logic    o_dcDone;
    wordT    o_dcData;
    logic    i_redirect;
    addrT    i_redirectPc;
    logic    o_instValid;
    wordT    o_inst;
    addrT    o_instPc;
    logic    i_instReady;

    // reference copy of the RAM contents
    byteT model [Depth];

    logic stallOn;
    logic backPressureOn;
    addrT expPc;
    int   instCount;
    int   loadCount;
    int   cycles;

    memSubsys #(
        .RAM_ADDR_W (RamAddrW)
    ) dut (
        .clk          (clk),
        .rst          (rst),
        .i_rdy        (i_rdy),
        .i_ioFull     (i_ioFull),
        .i_dcEn       (i_dcEn),
        .i_dcReq      (i_dcReq),
        .o_dcDone     (o_dcDone),
        .o_dcData     (o_dcData),
        .i_redirect   (i_redirect),
        .i_redirectPc (i_redirectPc),
        .o_instValid  (o_instValid),
        .o_inst       (o_inst),
        .o_instPc     (o_instPc),
        .i_instReady  (i_instReady)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic failNow(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    // zero-extended little endian bytes from the model
    function automatic wordT modelRead(input addrT addr, input lenT len);
        wordT val;
        val = '0;
        for (int k = 0; k < int'(len); k++) begin
            val[8*k +: 8] = model[(addr + addrT'(k)) % Depth];
        end
        return val;
    endfunction

    task automatic dataOp(input logic isStore, input lenT len, input addrT addr,
                          input wordT wdata);
        dataReqT req;
        wordT    expected;
        req.isStore = isStore;
        req.len     = len;
        req.addr    = addr;
        req.wdata   = wdata;
        @(negedge clk);
        i_dcReq = req;
        i_dcEn  = 1'b1;
        do begin
            @(posedge clk);
        end while (!o_dcDone);
        if (isStore) begin
            for (int k = 0; k < int'(len); k++) begin
                model[(addr + addrT'(k)) % Depth] = wdata[8*k +: 8];
            end
        end else begin
            expected = modelRead(addr, len);
            loadCount++;
            assert (o_dcData == expected)
                else failNow($sformatf("load addr %h len %0d got %h expected %h",
                                       addr, len, o_dcData, expected));
        end
        @(negedge clk);
        i_dcEn = 1'b0;
    endtask

    // random access of 1, 2 or 4 bytes below addrSpan
    task automatic randomOp(input int addrSpan);
        lenT len;
        case ($urandom % 3)
            0:       len = 3'd1;
            1:       len = 3'd2;
            default: len = 3'd4;
        endcase
        dataOp(1'($urandom % 2), len, addrT'($urandom % addrSpan), wordT'($urandom));
    endtask

    task automatic redirectTo(input addrT pc);
        @(negedge clk);
        i_redirect   = 1'b1;
        i_redirectPc = pc;
        @(negedge clk);
        i_redirect = 1'b0;
    endtask

    task automatic waitInsts(input int n);
        int target;
        target = instCount + n;
        while (instCount < target) begin
            @(negedge clk);
        end
    endtask

    // stall and back-pressure stimulus
    always @(negedge clk) begin
        if (stallOn) begin
            i_rdy    = ($urandom % 4) != 0;
            i_ioFull = ($urandom % 5) == 0;
        end else begin
            i_rdy    = 1'b1;
            i_ioFull = 1'b0;
        end
        i_instReady = backPressureOn ? (($urandom % 3) != 0) : 1'b1;
    end

    // every consumed instruction must follow the pc sequence and match memory
    always @(posedge clk) begin
        if (!rst && o_instValid && i_instReady) begin
            assert (o_instPc == expPc)
                else failNow($sformatf("instruction pc %h expected %h", o_instPc, expPc));
            assert (o_inst == modelRead(expPc, 3'd4))
                else failNow($sformatf("instruction at %h got %h expected %h",
                                       expPc, o_inst, modelRead(expPc, 3'd4)));
            expPc = expPc + 32'd4;
            instCount++;
        end
        if (!rst && i_redirect) begin
            expPc = i_redirectPc;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MaxCycles) begin
            $display("timeout: the run did not finish within %0d cycles", MaxCycles);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

    initial begin
        void'($urandom(47));
        for (int i = 0; i < Depth; i++) begin
            model[i] = '0;
        end
        rst            = 1'b1;
        i_rdy          = 1'b1;
        i_ioFull       = 1'b0;
        i_dcEn         = 1'b0;
        i_dcReq        = '0;
        i_redirect     = 1'b0;
        i_redirectPc   = '0;
        i_instReady    = 1'b1;
        stallOn        = 1'b0;
        backPressureOn = 1'b0;
        expPc          = '0;
        instCount      = 0;
        loadCount      = 0;
        cycles         = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // data port alone before the instruction region is loaded
        repeat (150) randomOp(32'h800);
        for (int i = 0; i < 128; i++) begin
            dataOp(1'b1, 3'd4, 32'h800 + 32'(4 * i), wordT'($urandom));
        end

        // instruction stream
        redirectTo(32'h800);
        waitInsts(30);

        // data traffic mixed with fetching
        redirectTo(32'h800);
        repeat (40) randomOp(32'h400);
        waitInsts(5);

        // everything again under random stalls
        stallOn = 1'b1;
        repeat (60) randomOp(32'h800);
        redirectTo(32'h840);
        repeat (30) randomOp(32'h400);
        waitInsts(10);

        // redirects into in-flight fetches with back-pressure
        backPressureOn = 1'b1;
        for (int r = 0; r < 12; r++) begin
            while (dut.uCtrl.state != CtrlReadInst) begin
                @(negedge clk);
            end
            redirectTo(32'h800 + 32'(4 * ($urandom % 64)));
            waitInsts(1 + $urandom % 8);
        end
        stallOn        = 1'b0;
        backPressureOn = 1'b0;
        waitInsts(5);

        if (loadCount == 0 || instCount == 0) begin
            $display("no loads or no instructions were checked");
            $display("SIMULATION FAILED");
            $fatal(1);
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule
